/* pkt_filter_pkg.sv */
// shared constants, address union and frame-kind helpers for the rx frame filter; import where needed
`default_nettype none

package pkt_filter_pkg;

    localparam int FILTER_CFG_W = 14;
    localparam int DISCARD_W    = 9;

    // bit positions follow enum ieee80211_filter_flags, bits 0, 2 and 3 reserved
    localparam int FIF_ALLMULTI_BIT            = 1;
    localparam int FIF_BCN_PRBRESP_PROMISC_BIT = 4;
    localparam int FIF_CONTROL_BIT             = 5;
    localparam int FIF_OTHER_BSS_BIT           = 6;
    localparam int FIF_PSPOLL_BIT              = 7;
    localparam int FIF_PROBE_REQ_BIT           = 8;
    localparam int UNICAST_FOR_US_BIT          = 9;
    localparam int BROADCAST_ALL_ONE_BIT       = 10;
    localparam int BROADCAST_ALL_ZERO_BIT      = 11;
    localparam int MY_BEACON_BIT               = 12;
    localparam int MONITOR_ALL_BIT             = 13;

    // header bytes needed before each address is complete
    localparam logic [15:0] MIN_LEN_ADDR1 = 16'd14;
    localparam logic [15:0] MIN_LEN_ADDR2 = 16'd20;
    localparam logic [15:0] MIN_LEN_ADDR3 = 16'd26;

    localparam logic [23:0] MCAST_IPV4_PREFIX = 24'h5E0001; // 01:00:5e, first byte in [7:0]
    localparam logic [15:0] MCAST_IPV6_PREFIX = 16'h3333;
    localparam logic [47:0] BCAST_ONES        = 48'hFFFF_FFFF_FFFF;
    localparam logic [47:0] BCAST_ZEROS       = 48'h0000_0000_0000;

    // header tracker states
    localparam logic [2:0] ST_IDLE     = 3'd0;
    localparam logic [2:0] ST_WAIT_A1  = 3'd1;
    localparam logic [2:0] ST_WAIT_A2  = 3'd2;
    localparam logic [2:0] ST_WAIT_A3  = 3'd3;
    localparam logic [2:0] ST_DONE     = 3'd4;
    localparam logic [2:0] ST_ABNORMAL = 3'd5;

    typedef union packed {
        logic [47:0] word;
        struct packed {
            logic [23:0] hi;
            logic [23:0] lo; // first three bytes on air
        } half;
    } mac_addr_u;

    typedef enum logic [3:0] {
        FK_BEACON, FK_PROBE_REQ, FK_PROBE_RESP, FK_CTRL_WRAPPER, FK_BAR, FK_BA, FK_PSPOLL,
        FK_RTS, FK_ACK, FK_CFEND, FK_CFEND_ACK, FK_CTRL_OTHER, FK_OTHER
    } frame_kind_e;

    function automatic frame_kind_e decode_frame_kind(input logic [1:0] ftype,
                                                      input logic [3:0] fsub);
        frame_kind_e kind;
        kind = FK_OTHER;
        if (ftype == 2'd0)          // management
        begin
            case (fsub)
                4'd4:    kind = FK_PROBE_REQ;
                4'd5:    kind = FK_PROBE_RESP;
                4'd8:    kind = FK_BEACON;
                default: kind = FK_OTHER;
            endcase
        end
        else if (ftype == 2'd1)     // control
        begin
            case (fsub)
                4'd7:    kind = FK_CTRL_WRAPPER;
                4'd8:    kind = FK_BAR;
                4'd9:    kind = FK_BA;
                4'd10:   kind = FK_PSPOLL;
                4'd11:   kind = FK_RTS;
                4'd13:   kind = FK_ACK;
                4'd14:   kind = FK_CFEND;
                4'd15:   kind = FK_CFEND_ACK;
                default: kind = FK_CTRL_OTHER;
            endcase
        end
        return kind;
    endfunction

    function automatic logic is_ctrl_kind(input frame_kind_e kind);
        return kind inside {FK_CTRL_WRAPPER, FK_BAR, FK_BA, FK_PSPOLL, FK_RTS, FK_ACK,
                            FK_CFEND, FK_CFEND_ACK, FK_CTRL_OTHER};
    endfunction

endpackage

`default_nettype wire

/* hdr_tracker.sv */
// follows the rx header strobes, checks lengths and captures bssid, addr1 and frame kind
`timescale 1ns/1ns
`default_nettype none

module hdr_tracker
    import pkt_filter_pkg::*;
(
    input  wire              clk,
    input  wire              rstn,
    input  wire [15:0]       max_len_th,
    input  wire              sig_valid,
    input  wire [15:0]       signal_len,
    input  wire              ht_unsupport,
    input  wire [1:0]        fc_type,
    input  wire [3:0]        fc_subtype,
    input  wire [1:0]        fc_tofrom_ds,
    input  wire              addr1_valid,
    input  wire mac_addr_u   addr1,
    input  wire              addr2_valid,
    input  wire mac_addr_u   addr2,
    input  wire              addr3_valid,
    input  wire mac_addr_u   addr3,
    output logic             hdr_done,
    output logic             hdr_abnormal,
    output frame_kind_e      hdr_kind,
    output mac_addr_u        hdr_addr1,
    output mac_addr_u        bssid,
    output logic             bssid_valid
);

    logic [2:0]  state;
    logic [15:0] frame_len;     // signal_len is only valid with sig_valid
    logic        frame_start;
    logic        len_bad;
    logic        bssid_load;
    mac_addr_u   bssid_next;
    logic        a1_last;
    logic        a2_last;

    assign frame_start = sig_valid && !ht_unsupport;
    assign len_bad     = (signal_len < MIN_LEN_ADDR1) || (signal_len > max_len_th);

    // short control frames end after addr1 or addr2
    assign a1_last = (hdr_kind == FK_CTRL_WRAPPER) || (hdr_kind == FK_ACK);
    assign a2_last = hdr_kind inside {FK_RTS, FK_PSPOLL, FK_CFEND, FK_CFEND_ACK, FK_BAR, FK_BA};

    // bssid slot depends on to/from-DS
    always_comb
    begin
        bssid_load = 1'b0;
        bssid_next = addr3;
        case (state)
            ST_WAIT_A1:
            begin
                bssid_load = addr1_valid && (fc_tofrom_ds == 2'b10);
                bssid_next = addr1;
            end
            ST_WAIT_A2:
            begin
                bssid_load = addr2_valid && (fc_tofrom_ds == 2'b01);
                bssid_next = addr2;
            end
            ST_WAIT_A3:
            begin
                bssid_load = addr3_valid && (fc_tofrom_ds == 2'b00);
            end
            default:
            begin
                bssid_load = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state       <= ST_IDLE;
            bssid_valid <= 1'b0;
        end
        else
        begin
            if (bssid_load)
                bssid_valid <= 1'b1; // sticky across frames
            case (state)
                ST_IDLE:
                begin
                    if (frame_start)
                        state <= len_bad ? ST_ABNORMAL : ST_WAIT_A1;
                end
                ST_WAIT_A1:
                begin
                    if (addr1_valid)
                    begin
                        if (a1_last)
                            state <= ST_DONE;
                        else if (frame_len >= MIN_LEN_ADDR2)
                            state <= ST_WAIT_A2;
                        else
                            state <= ST_ABNORMAL;
                    end
                end
                ST_WAIT_A2:
                begin
                    if (addr2_valid)
                    begin
                        if (a2_last)
                            state <= ST_DONE;
                        else if (frame_len >= MIN_LEN_ADDR3)
                            state <= ST_WAIT_A3;
                        else
                            state <= ST_ABNORMAL;
                    end
                end
                ST_WAIT_A3:
                begin
                    if (addr3_valid)
                        state <= ST_DONE;
                end
                default:
                begin
                    state <= ST_IDLE; // done and abnormal last one cycle
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == ST_IDLE) && frame_start)
        begin
            frame_len <= signal_len;
            hdr_kind  <= decode_frame_kind(fc_type, fc_subtype);
        end
        if ((state == ST_WAIT_A1) && addr1_valid)
            hdr_addr1 <= addr1;
        if (bssid_load)
            bssid <= bssid_next;
    end

    assign hdr_done     = (state == ST_DONE) || (state == ST_ABNORMAL);
    assign hdr_abnormal = (state == ST_ABNORMAL);

endmodule

`default_nettype wire

/* rule_eval.sv */
// evaluates the filter flags on a finished header and holds the dma block verdict
`timescale 1ns/1ns
`default_nettype none

module rule_eval
    import pkt_filter_pkg::*;
(
    input  wire                    clk,
    input  wire                    rstn,
    input  wire [FILTER_CFG_W-1:0] filter_cfg,
    input  wire [DISCARD_W-1:0]    discard_mask,
    input  wire mac_addr_u         self_mac_addr,
    input  wire mac_addr_u         self_bssid,
    input  wire                    hdr_done,
    input  wire                    hdr_abnormal,
    input  wire frame_kind_e       hdr_kind,
    input  wire mac_addr_u         hdr_addr1,
    input  wire mac_addr_u         bssid,
    input  wire                    bssid_valid,
    output logic                   verdict_valid,
    output logic                   block
);

    logic                    is_mcast;
    logic                    to_self;
    logic                    bcn_or_presp;
    logic                    ctrl_no_pspoll;
    logic                    other_bss;
    logic                    my_bss;
    logic [FILTER_CFG_W-1:0] cond;       // per-flag frame condition
    logic [DISCARD_W-1:0]    disc_cond;
    logic [FILTER_CFG_W-1:0] allow_d;
    logic [DISCARD_W-1:0]    discard_d;
    logic [FILTER_CFG_W-1:0] allow_q;
    logic [DISCARD_W-1:0]    discard_q;

    assign is_mcast       = (hdr_addr1.half.lo == MCAST_IPV4_PREFIX) ||
                            (hdr_addr1.half.lo[15:0] == MCAST_IPV6_PREFIX);
    assign to_self        = (hdr_addr1.word == self_mac_addr.word);
    assign bcn_or_presp   = (hdr_kind == FK_BEACON) || (hdr_kind == FK_PROBE_RESP);
    assign ctrl_no_pspoll = is_ctrl_kind(hdr_kind) && (hdr_kind != FK_PSPOLL);
    assign other_bss      = bssid_valid && (bssid.word != self_bssid.word);
    assign my_bss         = bssid_valid && (bssid.word == self_bssid.word);

    always_comb
    begin
        cond = '0;
        cond[FIF_ALLMULTI_BIT]            = is_mcast;
        cond[FIF_BCN_PRBRESP_PROMISC_BIT] = bcn_or_presp;
        cond[FIF_CONTROL_BIT]             = to_self && ctrl_no_pspoll;
        cond[FIF_OTHER_BSS_BIT]           = other_bss;
        cond[FIF_PSPOLL_BIT]              = (hdr_kind == FK_PSPOLL);
        cond[FIF_PROBE_REQ_BIT]           = (hdr_kind == FK_PROBE_REQ);
        cond[UNICAST_FOR_US_BIT]          = to_self;
        cond[BROADCAST_ALL_ONE_BIT]       = (hdr_addr1.word == BCAST_ONES);
        cond[BROADCAST_ALL_ZERO_BIT]      = (hdr_addr1.word == BCAST_ZEROS);
        cond[MY_BEACON_BIT]               = my_bss && (hdr_kind == FK_BEACON);
        cond[MONITOR_ALL_BIT]             = 1'b1;

        // discard side is looser for control and stricter for beacons
        disc_cond = cond[DISCARD_W-1:0];
        disc_cond[FIF_BCN_PRBRESP_PROMISC_BIT] = bcn_or_presp && other_bss;
        disc_cond[FIF_CONTROL_BIT]             = ctrl_no_pspoll;

        if (hdr_abnormal)
        begin
            allow_d   = '0;
            discard_d = '1;
        end
        else
        begin
            allow_d   = filter_cfg & cond;
            discard_d = ~filter_cfg[DISCARD_W-1:0] & disc_cond;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            verdict_valid <= 1'b0;
            allow_q       <= '0;
            discard_q     <= '0;
        end
        else
        begin
            verdict_valid <= hdr_done;
            if (hdr_done)
            begin
                allow_q   <= allow_d;
                discard_q <= discard_d;
            end
        end
    end

    // monitor-all overrides everything, otherwise need an allow and no masked discard
    assign block = !filter_cfg[MONITOR_ALL_BIT] &&
                   (!(|allow_q) || (|(discard_q & discard_mask)));

endmodule

`default_nettype wire

/* pkt_filter_top.sv */
// rx frame filter top level, header tracker feeding the rule evaluator
`timescale 1ns/1ns
`default_nettype none

module pkt_filter_top
    import pkt_filter_pkg::*;
(
    input  wire                    clk,
    input  wire                    rstn,
    input  wire [FILTER_CFG_W-1:0] filter_cfg,
    input  wire [DISCARD_W-1:0]    discard_mask,
    input  wire [15:0]             max_len_th,
    input  wire mac_addr_u         self_mac_addr,
    input  wire mac_addr_u         self_bssid,
    input  wire                    sig_valid,
    input  wire [15:0]             signal_len,
    input  wire                    ht_unsupport,
    input  wire [1:0]              fc_type,
    input  wire [3:0]              fc_subtype,
    input  wire [1:0]              fc_tofrom_ds,
    input  wire                    addr1_valid,
    input  wire mac_addr_u         addr1,
    input  wire                    addr2_valid,
    input  wire mac_addr_u         addr2,
    input  wire                    addr3_valid,
    input  wire mac_addr_u         addr3,
    output logic                   verdict_valid,
    output logic                   block
);

    logic        hdr_done;
    logic        hdr_abnormal;
    frame_kind_e hdr_kind;
    mac_addr_u   hdr_addr1;
    mac_addr_u   bssid;
    logic        bssid_valid;

    hdr_tracker u_hdr_tracker (
        .clk          (clk),
        .rstn         (rstn),
        .max_len_th   (max_len_th),
        .sig_valid    (sig_valid),
        .signal_len   (signal_len),
        .ht_unsupport (ht_unsupport),
        .fc_type      (fc_type),
        .fc_subtype   (fc_subtype),
        .fc_tofrom_ds (fc_tofrom_ds),
        .addr1_valid  (addr1_valid),
        .addr1        (addr1),
        .addr2_valid  (addr2_valid),
        .addr2        (addr2),
        .addr3_valid  (addr3_valid),
        .addr3        (addr3),
        .hdr_done     (hdr_done),
        .hdr_abnormal (hdr_abnormal),
        .hdr_kind     (hdr_kind),
        .hdr_addr1    (hdr_addr1),
        .bssid        (bssid),
        .bssid_valid  (bssid_valid)
    );

    rule_eval u_rule_eval (
        .clk           (clk),
        .rstn          (rstn),
        .filter_cfg    (filter_cfg),
        .discard_mask  (discard_mask),
        .self_mac_addr (self_mac_addr),
        .self_bssid    (self_bssid),
        .hdr_done      (hdr_done),
        .hdr_abnormal  (hdr_abnormal),
        .hdr_kind      (hdr_kind),
        .hdr_addr1     (hdr_addr1),
        .bssid         (bssid),
        .bssid_valid   (bssid_valid),
        .verdict_valid (verdict_valid),
        .block         (block)
    );

endmodule

`default_nettype wire

/* pkt_filter_asserts.sv */
// protocol assertions on the verdict strobe and tracker handshake, bound into the filter top
`timescale 1ns/1ns
`default_nettype none

module pkt_filter_asserts (
    input wire clk,
    input wire rstn,
    input wire sig_valid,
    input wire ht_unsupport,
    input wire hdr_done,
    input wire verdict_valid
);

    a_verdict_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        verdict_valid |=> !verdict_valid)
        else $error("verdict_valid held for two cycles");

    a_done_then_verdict: assert property (@(posedge clk) disable iff (!rstn)
        hdr_done |=> verdict_valid)
        else $error("verdict_valid did not follow hdr_done");

    // a new frame must not start while the previous header is finishing
    a_no_start_on_done: assert property (@(posedge clk) disable iff (!rstn)
        !(hdr_done && sig_valid && !ht_unsupport))
        else $error("frame started while hdr_done was high");

endmodule

bind pkt_filter_top pkt_filter_asserts u_pkt_filter_asserts (
    .clk           (clk),
    .rstn          (rstn),
    .sig_valid     (sig_valid),
    .ht_unsupport  (ht_unsupport),
    .hdr_done      (hdr_done),
    .verdict_valid (verdict_valid)
);

`default_nettype wire

/* tb_pkt_filter.sv */
// table-driven testbench for the rx frame filter, run as the simulation top with the file list
`timescale 1ns/1ns
`default_nettype none

module tb_pkt_filter
    import pkt_filter_pkg::*;
;

    localparam int NUM_ROWS = 29;
    localparam int CLK_NS   = 20;

    // self lo16 carries the ipv6 multicast prefix so one row can hit unicast and multicast
    localparam logic [47:0] SELF_MAC    = 48'h6655_4477_3333;
    localparam logic [47:0] SELF_BSS    = 48'hAABB_CCDD_EE02;
    localparam logic [47:0] OTHER_STA   = 48'h1010_1020_2002;
    localparam logic [47:0] OTHER_BSS   = 48'h7788_99CC_DD04;
    localparam logic [47:0] MC4_ADDR    = 48'h1234_565E_0001;
    localparam logic [47:0] MC6_ADDR    = 48'h1234_5678_3333;

    localparam logic [13:0] F_AMC  = 14'h0002;
    localparam logic [13:0] F_PROM = 14'h0010;
    localparam logic [13:0] F_CTL  = 14'h0020;
    localparam logic [13:0] F_OBSS = 14'h0040;
    localparam logic [13:0] F_PSP  = 14'h0080;
    localparam logic [13:0] F_PRQ  = 14'h0100;
    localparam logic [13:0] F_UNI  = 14'h0200;
    localparam logic [13:0] F_BC1  = 14'h0400;
    localparam logic [13:0] F_BC0  = 14'h0800;
    localparam logic [13:0] F_MYB  = 14'h1000;
    localparam logic [13:0] F_MON  = 14'h2000;

    logic                    clk;
    logic                    rstn;
    logic [FILTER_CFG_W-1:0] filter_cfg;
    logic [DISCARD_W-1:0]    discard_mask;
    logic [15:0]             max_len_th;
    mac_addr_u               self_mac_addr;
    mac_addr_u               self_bssid;
    logic                    sig_valid;
    logic [15:0]             signal_len;
    logic                    ht_unsupport;
    logic [1:0]              fc_type;
    logic [3:0]              fc_subtype;
    logic [1:0]              fc_tofrom_ds;
    logic                    addr1_valid;
    mac_addr_u               addr1;
    logic                    addr2_valid;
    mac_addr_u               addr2;
    logic                    addr3_valid;
    mac_addr_u               addr3;
    logic                    verdict_valid;
    logic                    block;

    logic [FILTER_CFG_W-1:0] tab_cfg [NUM_ROWS];
    logic [DISCARD_W-1:0]    tab_mask [NUM_ROWS];
    logic [15:0]             tab_max [NUM_ROWS];
    logic [1:0]              tab_type [NUM_ROWS];
    logic [3:0]              tab_sub [NUM_ROWS];
    logic [1:0]              tab_ds [NUM_ROWS];
    logic [15:0]             tab_len [NUM_ROWS];
    logic                    tab_ht [NUM_ROWS];
    int                      tab_naddr [NUM_ROWS];   // strobes the header needs
    logic [47:0]             tab_a1 [NUM_ROWS];
    logic [47:0]             tab_a2 [NUM_ROWS];
    logic [47:0]             tab_a3 [NUM_ROWS];
    logic                    tab_block [NUM_ROWS];
    int                      row_count;
    int                      error_count;
    integer                  seed;

    pkt_filter_top u_pkt_filter_top (
        .clk           (clk),
        .rstn          (rstn),
        .filter_cfg    (filter_cfg),
        .discard_mask  (discard_mask),
        .max_len_th    (max_len_th),
        .self_mac_addr (self_mac_addr),
        .self_bssid    (self_bssid),
        .sig_valid     (sig_valid),
        .signal_len    (signal_len),
        .ht_unsupport  (ht_unsupport),
        .fc_type       (fc_type),
        .fc_subtype    (fc_subtype),
        .fc_tofrom_ds  (fc_tofrom_ds),
        .addr1_valid   (addr1_valid),
        .addr1         (addr1),
        .addr2_valid   (addr2_valid),
        .addr2         (addr2),
        .addr3_valid   (addr3_valid),
        .addr3         (addr3),
        .verdict_valid (verdict_valid),
        .block         (block)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial
    begin
        #(NUM_ROWS * 40 * CLK_NS);
        stop_on_error("watchdog expired before all rows finished");
    end

    task automatic stop_on_error(input string msg);
        error_count = error_count + 1;
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_block(input int row, input logic got, input logic exp);
        string msg;
        if (got !== exp)
        begin
            msg = $sformatf("FAIL block row %0d: got %h expected %h", row, got, exp);
            stop_on_error(msg);
        end
    endtask

    // ht-unsupported frames never start, so verdict_valid stays low for the window
    task automatic check_no_verdict(input int row);
        repeat (10)
        begin
            @(negedge clk);
            if (verdict_valid !== 1'b0)
                stop_on_error($sformatf("row %0d gave a verdict for an ignored frame", row));
        end
    endtask

    task automatic add_row(input logic [13:0] cfg, input logic [8:0] mask,
                           input logic [15:0] maxl, input logic [1:0] ftype,
                           input logic [3:0] fsub, input logic [1:0] ds,
                           input logic [15:0] len, input logic ht, input int naddr,
                           input logic [47:0] a1, input logic [47:0] a2,
                           input logic [47:0] a3, input logic exp);
        tab_cfg[row_count]   = cfg;
        tab_mask[row_count]  = mask;
        tab_max[row_count]   = maxl;
        tab_type[row_count]  = ftype;
        tab_sub[row_count]   = fsub;
        tab_ds[row_count]    = ds;
        tab_len[row_count]   = len;
        tab_ht[row_count]    = ht;
        tab_naddr[row_count] = naddr;
        tab_a1[row_count]    = a1;
        tab_a2[row_count]    = a2;
        tab_a3[row_count]    = a3;
        tab_block[row_count] = exp;
        row_count = row_count + 1;
    endtask

    // bssid is sticky, so row order matters for the beacon and other-bss rows
    task automatic load_table();
        // unicast and plain mismatch, data frames with no bssid slot
        add_row(F_UNI, 9'h000, 16'd64, 2'd2, 4'd0, 2'b11, 16'd30, 1'b0, 3,
                SELF_MAC, OTHER_STA, OTHER_STA, 1'b0);
        add_row(F_UNI, 9'h000, 16'd64, 2'd2, 4'd0, 2'b11, 16'd30, 1'b0, 3,
                OTHER_STA, OTHER_STA, OTHER_STA, 1'b1);
        // length failures, then again with monitor-all
        add_row(F_UNI, 9'h000, 16'd64, 2'd2, 4'd0, 2'b11, 16'd10, 1'b0, 0,
                SELF_MAC, OTHER_STA, OTHER_STA, 1'b1);
        add_row(F_UNI, 9'h000, 16'd64, 2'd2, 4'd0, 2'b11, 16'd18, 1'b0, 1,
                SELF_MAC, OTHER_STA, OTHER_STA, 1'b1);
        add_row(F_UNI, 9'h000, 16'd64, 2'd2, 4'd0, 2'b11, 16'd24, 1'b0, 2,
                SELF_MAC, OTHER_STA, OTHER_STA, 1'b1);
        add_row(F_UNI, 9'h000, 16'd64, 2'd2, 4'd0, 2'b11, 16'd100, 1'b0, 0,
                SELF_MAC, OTHER_STA, OTHER_STA, 1'b1);
        add_row(F_UNI | F_MON, 9'h000, 16'd64, 2'd2, 4'd0, 2'b11, 16'd10, 1'b0, 0,
                SELF_MAC, OTHER_STA, OTHER_STA, 1'b0);
        add_row(F_UNI | F_MON, 9'h000, 16'd64, 2'd2, 4'd0, 2'b11, 16'd18, 1'b0, 1,
                SELF_MAC, OTHER_STA, OTHER_STA, 1'b0);
        add_row(F_UNI | F_MON, 9'h000, 16'd64, 2'd2, 4'd0, 2'b11, 16'd24, 1'b0, 2,
                SELF_MAC, OTHER_STA, OTHER_STA, 1'b0);
        add_row(F_UNI | F_MON, 9'h000, 16'd64, 2'd2, 4'd0, 2'b11, 16'd100, 1'b0, 0,
                SELF_MAC, OTHER_STA, OTHER_STA, 1'b0);
        // full set of strobes, so a wrongly started frame would finish
        add_row(F_UNI, 9'h000, 16'd64, 2'd2, 4'd0, 2'b11, 16'd30, 1'b1, 3,
                SELF_MAC, OTHER_STA, OTHER_STA, 1'b1);
        // broadcast and multicast
        add_row(F_BC1, 9'h000, 16'd64, 2'd2, 4'd0, 2'b11, 16'd30, 1'b0, 3,
                BCAST_ONES, OTHER_STA, OTHER_STA, 1'b0);
        add_row(F_BC0, 9'h000, 16'd64, 2'd2, 4'd0, 2'b11, 16'd30, 1'b0, 3,
                BCAST_ZEROS, OTHER_STA, OTHER_STA, 1'b0);
        add_row(F_AMC, 9'h000, 16'd64, 2'd2, 4'd0, 2'b11, 16'd30, 1'b0, 3,
                MC4_ADDR, OTHER_STA, OTHER_STA, 1'b0);
        add_row(F_AMC, 9'h000, 16'd64, 2'd2, 4'd0, 2'b11, 16'd30, 1'b0, 3,
                MC6_ADDR, OTHER_STA, OTHER_STA, 1'b0);
        add_row(F_UNI, 9'h002, 16'd64, 2'd2, 4'd0, 2'b11, 16'd30, 1'b0, 3,
                SELF_MAC, OTHER_STA, OTHER_STA, 1'b1);
        // beacons, bssid from addr3
        add_row(F_MYB, 9'h000, 16'd64, 2'd0, 4'd8, 2'b00, 16'd40, 1'b0, 3,
                BCAST_ONES, OTHER_STA, SELF_BSS, 1'b0);
        add_row(F_BC1, 9'h010, 16'd64, 2'd0, 4'd8, 2'b00, 16'd40, 1'b0, 3,
                BCAST_ONES, OTHER_STA, OTHER_BSS, 1'b1);
        add_row(F_BC1 | F_PROM, 9'h010, 16'd64, 2'd0, 4'd8, 2'b00, 16'd40, 1'b0, 3,
                BCAST_ONES, OTHER_STA, OTHER_BSS, 1'b0);
        // control frames, ack ends after addr1, rts and ps-poll after addr2
        add_row(F_UNI, 9'h000, 16'd64, 2'd1, 4'd13, 2'b11, 16'd14, 1'b0, 1,
                SELF_MAC, OTHER_STA, OTHER_STA, 1'b0);
        add_row(F_CTL, 9'h020, 16'd64, 2'd1, 4'd11, 2'b11, 16'd20, 1'b0, 2,
                SELF_MAC, OTHER_STA, OTHER_STA, 1'b0);
        add_row(F_UNI, 9'h020, 16'd64, 2'd1, 4'd11, 2'b11, 16'd20, 1'b0, 2,
                SELF_MAC, OTHER_STA, OTHER_STA, 1'b1);
        add_row(F_PSP, 9'h000, 16'd64, 2'd1, 4'd10, 2'b11, 16'd20, 1'b0, 2,
                SELF_BSS, OTHER_STA, OTHER_STA, 1'b0);
        add_row(F_BC1, 9'h080, 16'd64, 2'd1, 4'd10, 2'b11, 16'd20, 1'b0, 2,
                SELF_BSS, OTHER_STA, OTHER_STA, 1'b1);
        // to-ds data, bssid from addr1
        add_row(F_OBSS, 9'h040, 16'd64, 2'd2, 4'd0, 2'b10, 16'd30, 1'b0, 3,
                OTHER_STA, SELF_MAC, OTHER_STA, 1'b0);
        add_row(F_BC1, 9'h040, 16'd64, 2'd2, 4'd0, 2'b10, 16'd30, 1'b0, 3,
                BCAST_ONES, SELF_MAC, OTHER_STA, 1'b1);
        add_row(F_BC1, 9'h000, 16'd64, 2'd2, 4'd0, 2'b10, 16'd30, 1'b0, 3,
                BCAST_ONES, SELF_MAC, OTHER_STA, 1'b0);
        // probe request
        add_row(F_PRQ, 9'h000, 16'd64, 2'd0, 4'd4, 2'b11, 16'd30, 1'b0, 3,
                BCAST_ONES, OTHER_STA, BCAST_ONES, 1'b0);
        add_row(F_BC1, 9'h100, 16'd64, 2'd0, 4'd4, 2'b11, 16'd30, 1'b0, 3,
                BCAST_ONES, OTHER_STA, BCAST_ONES, 1'b1);
    endtask

    task automatic send_addr(input int slot);
        int gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(negedge clk);
        case (slot)
            1:       addr1_valid = 1'b1;
            2:       addr2_valid = 1'b1;
            default: addr3_valid = 1'b1;
        endcase
        @(negedge clk);
        addr1_valid = 1'b0;
        addr2_valid = 1'b0;
        addr3_valid = 1'b0;
    endtask

    task automatic wait_verdict(input int row);
        int cycles;
        cycles = 0;
        while (verdict_valid !== 1'b1)
        begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles > 30)
                stop_on_error($sformatf("row %0d never produced a verdict", row));
        end
    endtask

    task automatic run_row(input int row);
        filter_cfg        = tab_cfg[row];
        discard_mask      = tab_mask[row];
        max_len_th        = tab_max[row];
        fc_type           = tab_type[row];
        fc_subtype        = tab_sub[row];
        fc_tofrom_ds      = tab_ds[row];
        addr1.word        = tab_a1[row];
        addr2.word        = tab_a2[row];
        addr3.word        = tab_a3[row];
        signal_len        = tab_len[row];
        ht_unsupport      = tab_ht[row];
        sig_valid         = 1'b1;
        @(negedge clk);
        sig_valid = 1'b0;
        for (int s = 1; s <= tab_naddr[row]; s++)
            send_addr(s);
        if (tab_ht[row])
        begin
            check_no_verdict(row);
        end
        else
        begin
            wait_verdict(row);
            check_block(row, block, tab_block[row]);
        end
        ht_unsupport = 1'b0;
        @(negedge clk);
    endtask

    initial
    begin
        seed               = 32'hd5a4_000a;
        error_count        = 0;
        row_count          = 0;
        rstn               = 1'b0;
        filter_cfg         = '0;
        discard_mask       = '0;
        max_len_th         = 16'd64;
        self_mac_addr.word = SELF_MAC;
        self_bssid.word    = SELF_BSS;
        sig_valid          = 1'b0;
        signal_len         = '0;
        ht_unsupport       = 1'b0;
        fc_type            = '0;
        fc_subtype         = '0;
        fc_tofrom_ds       = '0;
        addr1_valid        = 1'b0;
        addr1.word         = '0;
        addr2_valid        = 1'b0;
        addr2.word         = '0;
        addr3_valid        = 1'b0;
        addr3.word         = '0;
        load_table();
        if (row_count != NUM_ROWS)
            stop_on_error("stimulus table size does not match its row count");
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        if (verdict_valid !== 1'b0)
            stop_on_error($sformatf("FAIL verdict_valid after reset: got %h expected %h",
                                    verdict_valid, 1'b0));
        check_block(-1, block, 1'b1); // reset state blocks with monitor-all off
        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);
        if (error_count == 0)
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
        begin
            $display("TEST FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

/* pkt_filter.f */
pkt_filter_pkg.sv
hdr_tracker.sv
rule_eval.sv
pkt_filter_top.sv
pkt_filter_asserts.sv
tb_pkt_filter.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the filter testbench with verilator; exit status follows the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pkt_filter -f pkt_filter.f -o sim_pkt_filter
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_pkt_filter > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
